// File: source/motor_pkg.sv
// ------------------------------
// motor controller package
// address map, register types, opcodes
// and safety check constants
// ------------------------------
package motor_pkg;

    // ------------------------------
    // basic widths
    typedef logic [15:0] addr_t;        // host register address
    typedef logic [31:0] data_t;        // register data
    typedef logic [15:0] cur_t;         // unsigned current, command or feedback

    localparam int NUM_AXES   = 4;
    localparam int AXIS_IDX_W = $clog2(NUM_AXES);

    typedef logic [NUM_AXES-1:0]   axis_mask_t;  // one bit per axis
    typedef logic [AXIS_IDX_W-1:0] axis_idx_t;   // axis number minus one

    // ------------------------------
    // address map
    // addr[15:12] space, addr[7:4] channel, addr[3:0] offset
    localparam logic [3:0] ADDR_MAIN      = 4'h0;
    localparam logic [3:0] CHAN_BOARD     = 4'd0;   // channel 0 is the board
    localparam logic [3:0] OFF_DAC_CTRL   = 4'd0;   // r/w current command
    localparam logic [3:0] OFF_CUR_FB     = 4'd1;   // read-only feedback
    localparam logic [3:0] OFF_AXIS_STAT  = 4'd2;   // read-only axis status
    localparam logic [3:0] OFF_BOARD_STAT = 4'd0;

    localparam logic [15:0] BOARD_MAGIC = 16'h514c;  // top half of board status

    // amplifier safety
    localparam int SAFETY_HOLD  = 4;    // consecutive overcurrent samples
    localparam int SAFETY_CNT_W = $clog2(SAFETY_HOLD + 1);

    typedef logic [SAFETY_CNT_W-1:0] hold_cnt_t;
    localparam hold_cnt_t HOLD_LAST = hold_cnt_t'(SAFETY_HOLD - 1);

    // ------------------------------
    // host request, 49 bits
    typedef struct packed {
        logic  write;
        addr_t addr;
        data_t wdata;
    } reg_req_t;

    typedef enum logic [2:0] {
        OP_DAC_WR,
        OP_DAC_RD,
        OP_FB_RD,
        OP_STAT_RD,
        OP_BOARD_RD,
        OP_BOARD_CLR,      // clear amp disable latches by mask
        OP_UNMAPPED        // reads 0, no side effect
    } reg_op_e;

    typedef struct packed {
        logic      valid;
        reg_op_e   op;
        axis_idx_t axis;
        data_t     wdata;
    } dec_op_t;

    typedef enum logic [1:0] {
        HS_IDLE,
        HS_BUSY,
        HS_ACK
    } hs_state_e;

endpackage

// File: source/safety_check.sv
// ------------------------------
// amplifier safety check
// latches a disable when feedback stays
// above twice the command
// ------------------------------
module safety_check (
    input  logic            sysclk,
    input  logic            rst_n,
    input  motor_pkg::cur_t cur_fb,     // sampled feedback
    input  motor_pkg::cur_t cur_cmd,
    input  logic            clear,      // from board status write
    output logic            amp_disable
);

    logic [16:0]          fb_wide;
    logic [16:0]          limit;        // 2 * command
    logic                 over;
    motor_pkg::hold_cnt_t hold_cnt;     // overcurrent samples so far

    assign fb_wide = {1'b0, cur_fb};
    assign limit   = {cur_cmd, 1'b0};
    assign over    = fb_wide > limit;

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            hold_cnt    <= '0;
            amp_disable <= 1'b0;
        end else if (clear) begin
            // clear beats detection
            hold_cnt    <= '0;
            amp_disable <= 1'b0;
        end else if (!over) begin
            hold_cnt <= '0;               // run broken
        end else if (hold_cnt == motor_pkg::HOLD_LAST) begin
            amp_disable <= 1'b1;          // SAFETY_HOLD-th sample in a row
        end else begin
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

endmodule

// File: source/reg_decode.sv
// ------------------------------
// request decode
// four-phase req/ack handshake and
// address decode into one operation
// ------------------------------
module reg_decode (
    input  logic                sysclk,
    input  logic                rst_n,
    input  logic                req,
    input  motor_pkg::reg_req_t cmd,
    input  logic                done,    // from readback
    output logic                ack,
    output motor_pkg::dec_op_t  op
);

    motor_pkg::hs_state_e state;
    motor_pkg::reg_op_e   op_kind;    // opcode for current cmd
    logic [3:0]           space;
    logic [3:0]           chan;
    logic [3:0]           offset;

    assign space  = cmd.addr[15:12];
    assign chan   = cmd.addr[7:4];
    assign offset = cmd.addr[3:0];

    // ------------------------------
    // address decode
    always_comb begin
        op_kind = motor_pkg::OP_UNMAPPED;    // default, also other spaces
        if (space == motor_pkg::ADDR_MAIN) begin
            if (chan == motor_pkg::CHAN_BOARD) begin
                if (offset == motor_pkg::OFF_BOARD_STAT)
                    op_kind = cmd.write ? motor_pkg::OP_BOARD_CLR : motor_pkg::OP_BOARD_RD;
            end else if (chan <= 4'(motor_pkg::NUM_AXES)) begin
                case (offset)
                    motor_pkg::OFF_DAC_CTRL:
                        op_kind = cmd.write ? motor_pkg::OP_DAC_WR : motor_pkg::OP_DAC_RD;
                    motor_pkg::OFF_CUR_FB:
                        if (!cmd.write) op_kind = motor_pkg::OP_FB_RD;      // read-only
                    motor_pkg::OFF_AXIS_STAT:
                        if (!cmd.write) op_kind = motor_pkg::OP_STAT_RD;    // read-only
                    default: op_kind = motor_pkg::OP_UNMAPPED;
                endcase
            end
        end
    end

    // ------------------------------
    // handshake FSM
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state    <= motor_pkg::HS_IDLE;
            op.valid <= 1'b0;
        end else begin
            op.valid <= 1'b0;    // op lasts one cycle
            case (state)
                motor_pkg::HS_IDLE: begin
                    if (req) begin
                        state    <= motor_pkg::HS_BUSY;
                        op.valid <= 1'b1;
                        op.op    <= op_kind;
                        op.axis  <= chan[1:0] - 2'd1;    // channel 1..4 to axis 0..3
                        op.wdata <= cmd.wdata;
                    end
                end
                motor_pkg::HS_BUSY: if (done) state <= motor_pkg::HS_ACK;
                motor_pkg::HS_ACK:  if (!req) state <= motor_pkg::HS_IDLE;    // host let go
                default: state <= motor_pkg::HS_IDLE;
            endcase
        end
    end

    assign ack = (state == motor_pkg::HS_ACK);    // held while req stays high

endmodule

// File: source/axis_regs.sv
// ------------------------------
// axis registers
// DAC commands, feedback sampling and
// one safety check per axis
// ------------------------------
module axis_regs (
    input  logic                                          sysclk,
    input  logic                                          rst_n,
    input  motor_pkg::dec_op_t                            op,
    input  motor_pkg::cur_t [motor_pkg::NUM_AXES-1:0]     cur_fb,
    output motor_pkg::cur_t [motor_pkg::NUM_AXES-1:0]     cur_cmd,
    output motor_pkg::cur_t [motor_pkg::NUM_AXES-1:0]     fb_sampled,
    output motor_pkg::axis_mask_t                         amp_disable,
    output motor_pkg::dec_op_t                            op_done
);

    logic                  dac_wr;
    motor_pkg::axis_mask_t clear;    // per-axis latch clear

    assign dac_wr = op.valid && (op.op == motor_pkg::OP_DAC_WR);

    // board status write, wdata[3:0] is the clear mask
    assign clear = (op.valid && (op.op == motor_pkg::OP_BOARD_CLR))
                 ? op.wdata[motor_pkg::NUM_AXES-1:0] : '0;

    // ------------------------------
    // DAC command and feedback
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            cur_cmd    <= '0;
            fb_sampled <= '0;
        end else begin
            fb_sampled <= cur_fb;                        // every cycle
            if (dac_wr)
                cur_cmd[op.axis] <= op.wdata[15:0];      // low half only
        end
    end

    // forward op to readback, writes already applied
    always_ff @(posedge sysclk) begin
        if (!rst_n)
            op_done.valid <= 1'b0;
        else
            op_done <= op;
    end

    // ------------------------------
    // overcurrent detectors
    for (genvar i = 0; i < motor_pkg::NUM_AXES; i++) begin : g_safety
        safety_check i_safety_check (
            .sysclk      (sysclk),
            .rst_n       (rst_n),
            .cur_fb      (fb_sampled[i]),    // one cycle behind the input
            .cur_cmd     (cur_cmd[i]),
            .clear       (clear[i]),
            .amp_disable (amp_disable[i])
        );
    end

endmodule

// File: source/reg_readback.sv
// ------------------------------
// read-back selection
// picks read data by opcode and axis,
// registers it and signals completion
// ------------------------------
module reg_readback (
    input  logic                                      sysclk,
    input  logic                                      rst_n,
    input  motor_pkg::dec_op_t                        op_done,
    input  logic [3:0]                                board_id,
    input  motor_pkg::cur_t [motor_pkg::NUM_AXES-1:0] cur_cmd,
    input  motor_pkg::cur_t [motor_pkg::NUM_AXES-1:0] fb_sampled,
    input  motor_pkg::axis_mask_t                     amp_disable,
    output motor_pkg::data_t                          rdata,
    output logic                                      done
);

    motor_pkg::data_t rd_sel;
    motor_pkg::data_t board_stat;

    // magic | rsvd | board id | rsvd | disables
    assign board_stat = {motor_pkg::BOARD_MAGIC, 4'h0, board_id, 4'h0, amp_disable};

    // ------------------------------
    // data select
    always_comb begin
        case (op_done.op)
            motor_pkg::OP_DAC_RD:   rd_sel = {16'h0, cur_cmd[op_done.axis]};
            motor_pkg::OP_FB_RD:    rd_sel = {16'h0, fb_sampled[op_done.axis]};
            motor_pkg::OP_STAT_RD:  rd_sel = {31'h0, amp_disable[op_done.axis]};
            motor_pkg::OP_BOARD_RD: rd_sel = board_stat;
            default:                rd_sel = '0;    // writes and unmapped
        endcase
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            rdata <= '0;
            done  <= 1'b0;
        end else begin
            done <= op_done.valid;      // one-cycle pulse back to decode
            if (op_done.valid)
                rdata <= rd_sel;        // held until next completion
        end
    end

endmodule

// File: source/motor_ctrl_top.sv
// ------------------------------
// motor controller top
// board and axis registers behind
// one req/ack host port
// ------------------------------
module motor_ctrl_top (
    input  logic                                      sysclk,
    input  logic                                      rst_n,
    input  logic                                      req,
    input  motor_pkg::reg_req_t                       cmd,
    output logic                                      ack,
    output motor_pkg::data_t                          rdata,
    input  logic [3:0]                                board_id,    // rotary switch
    input  motor_pkg::cur_t [motor_pkg::NUM_AXES-1:0] cur_fb,
    output motor_pkg::cur_t [motor_pkg::NUM_AXES-1:0] cur_cmd,
    output motor_pkg::axis_mask_t                     amp_disable
);

    motor_pkg::dec_op_t                        op;          // decode to axis regs
    motor_pkg::dec_op_t                        op_done;     // axis regs to readback
    logic                                      done;
    motor_pkg::cur_t [motor_pkg::NUM_AXES-1:0] fb_sampled;

    // ------------------------------
    // decode
    reg_decode i_reg_decode (
        .sysclk (sysclk),
        .rst_n  (rst_n),
        .req    (req),
        .cmd    (cmd),
        .done   (done),
        .ack    (ack),
        .op     (op)
    );

    // execute
    axis_regs i_axis_regs (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .op          (op),
        .cur_fb      (cur_fb),
        .cur_cmd     (cur_cmd),
        .fb_sampled  (fb_sampled),
        .amp_disable (amp_disable),
        .op_done     (op_done)
    );

    // result
    reg_readback i_reg_readback (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .op_done     (op_done),
        .board_id    (board_id),
        .cur_cmd     (cur_cmd),
        .fb_sampled  (fb_sampled),
        .amp_disable (amp_disable),
        .rdata       (rdata),
        .done        (done)
    );

endmodule

// File: tests/motor_ctrl_chk.sv
// ------------------------------
// handshake and safety assertions
// bound into the controller top
// ------------------------------
module motor_ctrl_chk (
    input logic                  sysclk,
    input logic                  rst_n,
    input logic                  req,
    input logic                  ack,
    input motor_pkg::dec_op_t    op,
    input motor_pkg::axis_mask_t amp_disable
);

    motor_pkg::axis_mask_t clr_mask;    // latches cleared by this op
    int                    fail_cnt = 0;    // assertions failed so far

    assign clr_mask = (op.valid && op.op == motor_pkg::OP_BOARD_CLR)
                    ? op.wdata[motor_pkg::NUM_AXES-1:0] : '0;

    // ack held low through reset
    a_ack_reset: assert property (@(posedge sysclk) !rst_n |=> !ack)
        else begin
            fail_cnt++;
            $error("ack high during reset");
        end

    a_ack_req: assert property (@(posedge sysclk) disable iff (!rst_n) $rose(ack) |-> req)
        else begin
            fail_cnt++;
            $error("ack rose without req");
        end

    // a latch only falls on a clear write for that axis
    a_latch_hold: assert property (@(posedge sysclk) disable iff (!rst_n)
        ($past(amp_disable) & ~amp_disable & ~$past(clr_mask)) == '0)
        else begin
            fail_cnt++;
            $error("amp_disable fell without a clear");
        end

endmodule

// File: tests/motor_ctrl_tb.sv
// ------------------------------
// motor controller testbench
// random register traffic checked
// against a model of the board registers
// ------------------------------
module motor_ctrl_tb;

    localparam int N_XACT     = 200;
    localparam int CLK_PERIOD = 40;
    localparam int WATCHDOG_T = N_XACT * 20 * CLK_PERIOD + 10 * CLK_PERIOD;

    logic                                      sysclk = 1'b0;
    logic                                      rst_n;
    logic                                      req;
    motor_pkg::reg_req_t                       cmd;
    logic                                      ack;
    motor_pkg::data_t                          rdata;
    logic [3:0]                                board_id;
    motor_pkg::cur_t [motor_pkg::NUM_AXES-1:0] cur_fb;
    motor_pkg::cur_t [motor_pkg::NUM_AXES-1:0] cur_cmd;
    motor_pkg::axis_mask_t                     amp_disable;

    // reference model
    motor_pkg::cur_t [motor_pkg::NUM_AXES-1:0] dac_m;     // expected DAC values
    motor_pkg::axis_mask_t                     latch_m;   // expected disables
    integer seed    = 32'h1167_0a98;

    always #(CLK_PERIOD / 2) sysclk = ~sysclk;

    motor_ctrl_top i_motor_ctrl_top (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .req         (req),
        .cmd         (cmd),
        .ack         (ack),
        .rdata       (rdata),
        .board_id    (board_id),
        .cur_fb      (cur_fb),
        .cur_cmd     (cur_cmd),
        .amp_disable (amp_disable)
    );

    bind motor_ctrl_top motor_ctrl_chk i_motor_ctrl_chk (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .req         (req),
        .ack         (ack),
        .op          (op),
        .amp_disable (amp_disable)
    );

    // ------------------------------
    // compare tasks
    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input motor_pkg::data_t got,
                              input motor_pkg::data_t exp);
        if (got !== exp)
            report_error($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_mask(input string name, input motor_pkg::axis_mask_t got,
                              input motor_pkg::axis_mask_t exp);
        if (got !== exp)
            report_error($sformatf("FAIL t=%0t %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic check_cur(input string name, input motor_pkg::cur_t got,
                             input motor_pkg::cur_t exp);
        if (got !== exp)
            report_error($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        if (got != exp)
            report_error($sformatf("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp));
    endtask

    // ------------------------------
    // model rules
    function automatic logic over_limit(motor_pkg::cur_t fb, motor_pkg::cur_t cmd_val);
        return int'(fb) > 2 * int'(cmd_val);    // strictly above twice the command
    endfunction

    function automatic motor_pkg::data_t expect_rdata(motor_pkg::reg_req_t c);
        logic [3:0] chan;
        logic [3:0] off;
        int         a;
        chan = c.addr[7:4];
        off  = c.addr[3:0];
        a    = int'(chan) - 1;
        if (c.addr[15:12] != 4'h0 || c.write)
            return '0;    // writes and other spaces read 0
        if (chan == 4'd0)
            return (off == 4'd0) ? {motor_pkg::BOARD_MAGIC, 4'h0, board_id, 4'h0, latch_m} : '0;
        if (chan > 4'd4)
            return '0;
        case (off)
            4'd0:    return {16'h0, dac_m[a]};
            4'd1:    return {16'h0, cur_fb[a]};
            4'd2:    return {31'h0, latch_m[a]};
            default: return '0;
        endcase
    endfunction

    // returns 1 when the write touched DAC or latch state
    function automatic logic apply_write(motor_pkg::reg_req_t c);
        logic [3:0] chan;
        chan = c.addr[7:4];
        if (!c.write || c.addr[15:12] != 4'h0 || c.addr[3:0] != 4'd0)
            return 1'b0;
        if (chan == 4'd0) begin
            latch_m = latch_m & ~c.wdata[3:0];    // clear by mask
            return 1'b1;
        end
        if (chan <= 4'd4) begin
            dac_m[int'(chan) - 1] = c.wdata[15:0];
            return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic motor_pkg::reg_req_t random_req();
        motor_pkg::reg_req_t c;
        logic [31:0]         r;
        logic [3:0]          chan;
        logic [3:0]          off;
        logic [3:0]          space;
        r     = $random(seed);
        chan  = 4'(r[7:0] % 6);                          // 5 is an unused channel
        off   = (r[9:8] == 2'b11) ? r[13:10] : ((chan == 4'd0) ? 4'd0 : 4'(r[15:10] % 3));
        space = (r[18:16] == 3'd0) ? {1'b1, r[21:19]} : 4'h0;    // mostly main space
        c.write = r[31];
        c.addr  = {space, 4'h0, chan, off};
        c.wdata = $random(seed);
        return c;
    endfunction

    // ------------------------------
    // bus and settle tasks
    task automatic run_xact(input motor_pkg::reg_req_t c, output motor_pkg::data_t rd);
        int cyc;
        int hold;
        @(posedge sysclk);
        req <= 1'b1;
        cmd <= c;
        cyc = 0;
        do begin
            @(negedge sysclk);
            cyc++;
        end while (!ack && cyc < 20);
        // one negedge before the sampling edge, then 3 cycles, seen at the next negedge
        check_cycles("ack latency", cyc, 5);
        rd   = rdata;
        hold = {$random(seed)} % 3;           // host back-pressure
        repeat (hold) begin
            @(negedge sysclk);
            if (!ack) report_error("ack dropped while req was still high");
        end
        @(posedge sysclk);
        req <= 1'b0;
        @(negedge sysclk);
        if (!ack) report_error("ack fell before req was sampled low");
        @(negedge sysclk);
        if (ack) report_error("ack still high one cycle after req was sampled low");
    endtask

    task automatic settle_and_check();
        repeat (8) @(posedge sysclk);
        for (int i = 0; i < motor_pkg::NUM_AXES; i++)
            if (over_limit(cur_fb[i], dac_m[i])) latch_m[i] = 1'b1;
        @(negedge sysclk);
        check_mask("amp_disable", amp_disable, latch_m);
        for (int i = 0; i < motor_pkg::NUM_AXES; i++)
            check_cur($sformatf("cur_cmd[%0d]", i), cur_cmd[i], dac_m[i]);
    endtask

    // ------------------------------
    // main sequence
    initial begin
        motor_pkg::reg_req_t                       c;
        motor_pkg::data_t                          rd;
        motor_pkg::data_t                          rd_exp;
        motor_pkg::cur_t [motor_pkg::NUM_AXES-1:0] fb_next;
        logic [31:0]                               r;
        rst_n    <= 1'b0;
        req      <= 1'b0;
        cmd      <= '0;
        board_id <= 4'($random(seed));
        cur_fb   <= '0;
        dac_m   = '0;
        latch_m = '0;
        repeat (10) @(posedge sysclk);
        rst_n <= 1'b1;
        for (int n = 0; n < N_XACT; n++) begin
            r = $random(seed);
            if (r[0]) begin    // new feedback about every other transaction
                for (int i = 0; i < motor_pkg::NUM_AXES; i++) begin
                    r          = $random(seed);
                    fb_next[i] = r[16] ? {4'h0, r[11:0]} : r[15:0];    // some low values
                end
                @(posedge sysclk);
                cur_fb <= fb_next;
                settle_and_check();
            end
            c      = random_req();
            rd_exp = expect_rdata(c);
            run_xact(c, rd);
            check_data("rdata", rd, rd_exp);
            if (apply_write(c))
                settle_and_check();
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    // bound assertions
    initial begin
        wait (i_motor_ctrl_top.i_motor_ctrl_chk.fail_cnt != 0);
        report_error("a handshake or safety assertion in the checker failed");
    end

    // watchdog
    initial begin
        #(WATCHDOG_T);
        $display("watchdog expired before all transactions finished");
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    end

endmodule

// File: verilog.f
source/motor_pkg.sv
source/safety_check.sv
source/reg_decode.sv
source/axis_regs.sv
source/reg_readback.sv
source/motor_ctrl_top.sv
tests/motor_ctrl_chk.sv
tests/motor_ctrl_tb.sv

// File: Makefile
# Verilator flow for the motor controller
TOP := motor_ctrl_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f verilog.f --Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
